// File: hw/exec_pkg.sv
package exec_pkg;

    localparam int NUM_THREADS = 4;
    localparam int NUM_WARPS   = 8;
    localparam int ISSUE_CNT   = 4;
    localparam int XLEN        = 32;
    localparam int QUEUE_DEPTH = 2;

    // derived widths for ids, slice indices and queue bookkeeping
    localparam int WID_W   = $clog2(NUM_WARPS);
    localparam int SLICE_W = $clog2(ISSUE_CNT);
    localparam int QPTR_W  = $clog2(QUEUE_DEPTH);
    localparam int QCNT_W  = $clog2(QUEUE_DEPTH + 1);

    typedef logic [XLEN-1:0]        word_t;
    typedef logic [WID_W-1:0]       wid_t;
    typedef logic [SLICE_W-1:0]     slice_t;
    typedef logic [NUM_THREADS-1:0] tmask_t;
    typedef logic [QPTR_W-1:0]      qptr_t;
    typedef logic [QCNT_W-1:0]      qcnt_t;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, SLT, SLTU, MUL,
        BEQ, BNE, JAL, TMC, EBREAK, ECALL
    } alu_op_e;

    typedef struct packed {
        wid_t    wid;
        alu_op_e op;
        word_t   pc;
        word_t   rs1;
        word_t   rs2;
        word_t   imm;
    } dispatch_t;

    typedef struct packed {
        wid_t  wid;
        word_t pc;
        word_t result;
    } result_t;

    typedef struct packed {
        logic  valid;
        logic  taken;
        wid_t  wid;
        word_t dest;
    } branch_ctl_t;

    typedef struct packed {
        logic   valid;
        wid_t   wid;
        tmask_t tmask;
    } warp_ctl_t;

endpackage

// File: hw/issue_dispatcher.sv
module issue_dispatcher (
    input  logic                          disp_valid,
    input  exec_pkg::dispatch_t           disp_data,
    output logic [exec_pkg::ISSUE_CNT-1:0] slice_valid,
    output exec_pkg::dispatch_t           slice_data,
    output logic                          tmc_valid,
    output logic                          sim_ebreak
);

    logic             is_tmc;
    logic             is_trap;
    exec_pkg::slice_t target;

    assign is_tmc = (disp_data.op == exec_pkg::TMC);

    // ebreak and ecall share the same status strobe
    assign is_trap = (disp_data.op == exec_pkg::EBREAK) || (disp_data.op == exec_pkg::ECALL);

    // warps are spread over the slices by the low bits of their id
    assign target = exec_pkg::slice_t'(disp_data.wid);

    always_comb begin
        for (int i = 0; i < exec_pkg::ISSUE_CNT; i++) begin
            slice_valid[i] = disp_valid && !is_tmc && (target == exec_pkg::slice_t'(i));
        end
    end

    // every slice sees the same payload, only the valid bit selects one
    assign slice_data = disp_data;

    // thread mask changes are handled by warp control, not by a slice
    assign tmc_valid = disp_valid && is_tmc;

    // warp 0 reaching ebreak or ecall ends a test program
    assign sim_ebreak = disp_valid && is_trap && (disp_data.wid == '0);

endmodule

// File: hw/alu_slice.sv
module alu_slice (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  exec_pkg::dispatch_t   in_data,
    output logic                  res_valid,
    output exec_pkg::result_t     res_data,
    output exec_pkg::branch_ctl_t branch_ctl
);

    exec_pkg::word_t   next_pc;
    exec_pkg::word_t   alu_value;
    logic              is_mul;
    logic              is_branch;
    logic              br_taken;

    // single-cycle result register
    logic              alu_valid;
    exec_pkg::result_t alu_res;

    // multiply operand stage and product stage
    logic              mul_op_valid;
    exec_pkg::wid_t    mul_wid;
    exec_pkg::word_t   mul_pc;
    exec_pkg::word_t   mul_a;
    exec_pkg::word_t   mul_b;
    logic              mul_valid;
    exec_pkg::result_t mul_res;

    // holds the younger result when a product and a single-cycle op finish together
    logic              skid_valid;
    exec_pkg::result_t skid_res;
    logic              skid_load;
    exec_pkg::result_t skid_data;

    assign next_pc   = in_data.pc + exec_pkg::word_t'(4);
    assign is_mul    = (in_data.op == exec_pkg::MUL);
    assign is_branch = in_data.op inside {exec_pkg::BEQ, exec_pkg::BNE, exec_pkg::JAL};

    always_comb begin
        case (in_data.op)
            exec_pkg::BEQ: br_taken = (in_data.rs1 == in_data.rs2);
            exec_pkg::BNE: br_taken = (in_data.rs1 != in_data.rs2);
            exec_pkg::JAL: br_taken = 1'b1;
            default:       br_taken = 1'b0;
        endcase
    end

    always_comb begin
        case (in_data.op)
            exec_pkg::ADD:  alu_value = in_data.rs1 + in_data.rs2;
            exec_pkg::SUB:  alu_value = in_data.rs1 - in_data.rs2;
            exec_pkg::AND:  alu_value = in_data.rs1 & in_data.rs2;
            exec_pkg::OR:   alu_value = in_data.rs1 | in_data.rs2;
            exec_pkg::XOR:  alu_value = in_data.rs1 ^ in_data.rs2;
            exec_pkg::SLT:  alu_value = exec_pkg::word_t'($signed(in_data.rs1) < $signed(in_data.rs2));
            exec_pkg::SLTU: alu_value = exec_pkg::word_t'(in_data.rs1 < in_data.rs2);
            // control transfers write back the return address
            exec_pkg::BEQ, exec_pkg::BNE, exec_pkg::JAL,
            exec_pkg::EBREAK, exec_pkg::ECALL: alu_value = next_pc;
            default:        alu_value = '0;
        endcase
    end

    // the skid register never needs more than one entry since dispatch is one per cycle
    assign skid_load = (skid_valid && (mul_valid || alu_valid)) || (mul_valid && alu_valid);
    assign skid_data = (skid_valid && mul_valid) ? mul_res : alu_res;

    always_ff @(posedge clk) begin
        if (rst) begin
            alu_valid        <= 1'b0;
            mul_op_valid     <= 1'b0;
            mul_valid        <= 1'b0;
            skid_valid       <= 1'b0;
            branch_ctl.valid <= 1'b0;
        end else begin
            alu_valid        <= in_valid && !is_mul;
            mul_op_valid     <= in_valid && is_mul;
            mul_valid        <= mul_op_valid;
            skid_valid       <= skid_load;
            branch_ctl.valid <= in_valid && is_branch;
        end
        alu_res.wid       <= in_data.wid;
        alu_res.pc        <= in_data.pc;
        alu_res.result    <= alu_value;
        mul_wid           <= in_data.wid;
        mul_pc            <= in_data.pc;
        mul_a             <= in_data.rs1;
        mul_b             <= in_data.rs2;
        mul_res.wid       <= mul_wid;
        mul_res.pc        <= mul_pc;
        mul_res.result    <= mul_a * mul_b;
        skid_res          <= skid_data;
        branch_ctl.taken  <= br_taken;
        branch_ctl.wid    <= in_data.wid;
        branch_ctl.dest   <= in_data.pc + in_data.imm;
    end

    // oldest result goes out first
    always_comb begin
        res_valid = skid_valid || mul_valid || alu_valid;
        if (skid_valid) begin
            res_data = skid_res;
        end else if (mul_valid) begin
            res_data = mul_res;
        end else begin
            res_data = alu_res;
        end
    end

endmodule

// File: hw/commit_merger.sv
module commit_merger (
    input  logic                           clk,
    input  logic                           rst,
    input  logic [exec_pkg::ISSUE_CNT-1:0] res_valid,
    input  exec_pkg::result_t              res_data [exec_pkg::ISSUE_CNT],
    output logic                           commit_valid,
    output exec_pkg::result_t              commit_data
);

    exec_pkg::result_t q_mem [exec_pkg::ISSUE_CNT][exec_pkg::QUEUE_DEPTH];
    exec_pkg::qptr_t   q_wr_ptr [exec_pkg::ISSUE_CNT];
    exec_pkg::qptr_t   q_rd_ptr [exec_pkg::ISSUE_CNT];
    exec_pkg::qcnt_t   q_count [exec_pkg::ISSUE_CNT];

    exec_pkg::slice_t  last_grant;
    exec_pkg::slice_t  grant_idx;
    exec_pkg::slice_t  cand;
    logic              grant_valid;
    logic [exec_pkg::ISSUE_CNT-1:0] pop;

    // rotating priority, the search starts one past the last slice served
    always_comb begin
        grant_valid = 1'b0;
        grant_idx   = last_grant;
        cand        = last_grant;
        for (int k = 1; k <= exec_pkg::ISSUE_CNT; k++) begin
            cand = exec_pkg::slice_t'(last_grant + k);
            if (!grant_valid && (q_count[cand] != '0)) begin
                grant_valid = 1'b1;
                grant_idx   = cand;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < exec_pkg::ISSUE_CNT; i++) begin
            pop[i] = grant_valid && (grant_idx == exec_pkg::slice_t'(i));
        end
    end

    assign commit_valid = grant_valid;
    assign commit_data  = q_mem[grant_idx][q_rd_ptr[grant_idx]];

    always_ff @(posedge clk) begin
        for (int i = 0; i < exec_pkg::ISSUE_CNT; i++) begin
            if (res_valid[i]) begin
                q_mem[i][q_wr_ptr[i]] <= res_data[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            last_grant <= '0;
            for (int i = 0; i < exec_pkg::ISSUE_CNT; i++) begin
                q_wr_ptr[i] <= '0;
                q_rd_ptr[i] <= '0;
                q_count[i]  <= '0;
            end
        end else begin
            if (grant_valid) begin
                last_grant <= grant_idx;
            end
            for (int i = 0; i < exec_pkg::ISSUE_CNT; i++) begin
                if (res_valid[i]) begin
                    q_wr_ptr[i] <= (q_wr_ptr[i] == exec_pkg::qptr_t'(exec_pkg::QUEUE_DEPTH - 1))
                                 ? '0 : q_wr_ptr[i] + 1'b1;
                end
                if (pop[i]) begin
                    q_rd_ptr[i] <= (q_rd_ptr[i] == exec_pkg::qptr_t'(exec_pkg::QUEUE_DEPTH - 1))
                                 ? '0 : q_rd_ptr[i] + 1'b1;
                end
                // a push and a pop in the same cycle leave the count unchanged
                q_count[i] <= q_count[i] + exec_pkg::qcnt_t'(res_valid[i])
                                         - exec_pkg::qcnt_t'(pop[i]);
            end
        end
    end

endmodule

// File: hw/warp_ctl_unit.sv
module warp_ctl_unit (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           tmc_valid,
    input  exec_pkg::dispatch_t            tmc_data,
    input  exec_pkg::branch_ctl_t          branch_ctl [exec_pkg::ISSUE_CNT],
    output exec_pkg::warp_ctl_t            warp_ctl,
    output logic [exec_pkg::ISSUE_CNT-1:0] flush
);

    logic mask_cleared;

    // the new thread mask comes from the low bits of rs1
    always_ff @(posedge clk) begin
        if (rst) begin
            warp_ctl.valid <= 1'b0;
        end else begin
            warp_ctl.valid <= tmc_valid;
        end
        warp_ctl.wid   <= tmc_data.wid;
        warp_ctl.tmask <= exec_pkg::tmask_t'(tmc_data.rs1);
    end

    // a warp left with no active threads drains every slice
    assign mask_cleared = warp_ctl.valid && (warp_ctl.tmask == '0);

    always_comb begin
        for (int i = 0; i < exec_pkg::ISSUE_CNT; i++) begin
            flush[i] = (branch_ctl[i].valid && branch_ctl[i].taken) || mask_cleared;
        end
    end

endmodule

// File: hw/execute_scalar.sv
module execute_scalar (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           disp_valid,
    input  exec_pkg::dispatch_t            disp_data,
    output logic                           commit_valid,
    output exec_pkg::result_t              commit_data,
    output exec_pkg::branch_ctl_t          branch_ctl [exec_pkg::ISSUE_CNT],
    output exec_pkg::warp_ctl_t            warp_ctl,
    output logic [exec_pkg::ISSUE_CNT-1:0] flush,
    output logic                           sim_ebreak
);

    logic [exec_pkg::ISSUE_CNT-1:0] slice_valid;
    exec_pkg::dispatch_t            slice_data;
    logic                           tmc_valid;
    logic [exec_pkg::ISSUE_CNT-1:0] res_valid;
    exec_pkg::result_t              res_data [exec_pkg::ISSUE_CNT];

    issue_dispatcher dispatcher (
        .disp_valid  (disp_valid),
        .disp_data   (disp_data),
        .slice_valid (slice_valid),
        .slice_data  (slice_data),
        .tmc_valid   (tmc_valid),
        .sim_ebreak  (sim_ebreak)
    );

    for (genvar i = 0; i < exec_pkg::ISSUE_CNT; i++) begin : g_slice
        alu_slice slice (
            .clk        (clk),
            .rst        (rst),
            .in_valid   (slice_valid[i]),
            .in_data    (slice_data),
            .res_valid  (res_valid[i]),
            .res_data   (res_data[i]),
            .branch_ctl (branch_ctl[i])
        );
    end

    commit_merger merger (
        .clk          (clk),
        .rst          (rst),
        .res_valid    (res_valid),
        .res_data     (res_data),
        .commit_valid (commit_valid),
        .commit_data  (commit_data)
    );

    // flush combines taken branches from all slices with thread mask changes
    warp_ctl_unit warp_ctl_blk (
        .clk        (clk),
        .rst        (rst),
        .tmc_valid  (tmc_valid),
        .tmc_data   (slice_data),
        .branch_ctl (branch_ctl),
        .warp_ctl   (warp_ctl),
        .flush      (flush)
    );

endmodule

// File: testbench/tb_execute_scalar.sv
module tb_execute_scalar;

    logic                           clk;
    logic                           rst;
    logic                           disp_valid;
    exec_pkg::dispatch_t            disp_data;
    logic                           commit_valid;
    exec_pkg::result_t              commit_data;
    exec_pkg::branch_ctl_t          branch_ctl [exec_pkg::ISSUE_CNT];
    exec_pkg::warp_ctl_t            warp_ctl;
    logic [exec_pkg::ISSUE_CNT-1:0] flush;
    logic                           sim_ebreak;

    // expected commits are keyed by pc since slices may commit out of order
    exec_pkg::word_t exp_result [exec_pkg::word_t];
    exec_pkg::wid_t  exp_wid [exec_pkg::word_t];
    bit              seen [exec_pkg::word_t];

    // outputs due one cycle after a branch or TMC dispatch
    logic            br_due [exec_pkg::ISSUE_CNT];
    logic            br_taken_exp [exec_pkg::ISSUE_CNT];
    exec_pkg::word_t br_dest_exp [exec_pkg::ISSUE_CNT];
    exec_pkg::wid_t  br_wid_exp [exec_pkg::ISSUE_CNT];
    logic            tmc_due;
    exec_pkg::wid_t  tmc_wid_exp;
    exec_pkg::tmask_t tmc_mask_exp;

    int mismatches;
    int failures;
    int commit_count;
    int expected_commits;
    int fd;
    int idle;
    int wid_num;
    int op_num;
    int taken_num;
    int wait_cycles;
    exec_pkg::word_t pc;
    exec_pkg::word_t rs1;
    exec_pkg::word_t rs2;
    exec_pkg::word_t imm;
    exec_pkg::word_t res;
    logic [31:0]     mask_num;
    string           line;

    execute_scalar uut (
        .clk          (clk),
        .rst          (rst),
        .disp_valid   (disp_valid),
        .disp_data    (disp_data),
        .commit_valid (commit_valid),
        .commit_data  (commit_data),
        .branch_ctl   (branch_ctl),
        .warp_ctl     (warp_ctl),
        .flush        (flush),
        .sim_ebreak   (sim_ebreak)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, what, actual, expected);
        end
    endtask

    task automatic check_idle_outputs(input string when);
        check_value(commit_valid, 1'b0, {"commit_valid ", when});
        check_value(flush, '0, {"flush ", when});
        check_value(warp_ctl.valid, 1'b0, {"warp_ctl valid ", when});
    endtask

    // registered outputs are stable at the falling edge
    task automatic check_cycle_outputs();
        logic zero_mask;
        logic exp_flush;
        zero_mask = tmc_due && (tmc_mask_exp == '0);
        check_value(warp_ctl.valid, tmc_due, "warp_ctl valid");
        if (tmc_due) begin
            check_value(warp_ctl.wid, tmc_wid_exp, "warp_ctl wid");
            check_value(warp_ctl.tmask, tmc_mask_exp, "warp_ctl tmask");
        end
        for (int i = 0; i < exec_pkg::ISSUE_CNT; i++) begin
            check_value(branch_ctl[i].valid, br_due[i], $sformatf("slice %0d branch valid", i));
            if (br_due[i]) begin
                check_value(branch_ctl[i].taken, br_taken_exp[i],
                            $sformatf("slice %0d branch taken", i));
                check_value(branch_ctl[i].dest, br_dest_exp[i], $sformatf("slice %0d dest", i));
                check_value(branch_ctl[i].wid, br_wid_exp[i], $sformatf("slice %0d wid", i));
            end
            exp_flush = (br_due[i] && br_taken_exp[i]) || zero_mask;
            check_value(flush[i], exp_flush, $sformatf("flush bit %0d", i));
            br_due[i] = 1'b0;
        end
        tmc_due = 1'b0;
        if (commit_valid) begin
            commit_count++;
            if (!exp_result.exists(commit_data.pc)) begin
                failures++;
                $display("unexpected commit from pc %h at %0t", commit_data.pc, $time);
            end else if (seen.exists(commit_data.pc)) begin
                failures++;
                $display("pc %h committed more than once at %0t", commit_data.pc, $time);
            end else begin
                seen[commit_data.pc] = 1'b1;
                check_value(commit_data.wid, exp_wid[commit_data.pc],
                            $sformatf("commit wid for pc %h", commit_data.pc));
                check_value(commit_data.result, exp_result[commit_data.pc],
                            $sformatf("commit result for pc %h", commit_data.pc));
            end
        end
    endtask

    // each call checks the outputs of one clock and then drives new inputs on the falling edge
    task automatic drive_cycle(input logic valid, input exec_pkg::dispatch_t data);
        logic exp_ebreak;
        @(negedge clk);
        check_cycle_outputs();
        disp_valid = valid;
        disp_data  = data;
        exp_ebreak = valid && (data.wid == '0)
                     && ((data.op == exec_pkg::EBREAK) || (data.op == exec_pkg::ECALL));
        #1;
        check_value(sim_ebreak, exp_ebreak, "sim_ebreak");
    endtask

    task automatic issue_line();
        exec_pkg::dispatch_t d;
        int gap;
        int slice;
        // a zero idle count keeps the instruction back to back with the previous one
        gap = idle;
        if (idle > 0) begin
            gap = idle + ($urandom % 3);
        end
        repeat (gap) drive_cycle(1'b0, '0);
        d.wid = exec_pkg::wid_t'(wid_num);
        d.op  = exec_pkg::alu_op_e'(op_num);
        d.pc  = pc;
        d.rs1 = rs1;
        d.rs2 = rs2;
        d.imm = imm;
        drive_cycle(1'b1, d);
        slice = wid_num % exec_pkg::ISSUE_CNT;
        if (d.op inside {exec_pkg::BEQ, exec_pkg::BNE, exec_pkg::JAL}) begin
            br_due[slice]       = 1'b1;
            br_taken_exp[slice] = (taken_num != 0);
            br_dest_exp[slice]  = pc + imm;
            br_wid_exp[slice]   = d.wid;
        end
        if (d.op == exec_pkg::TMC) begin
            tmc_due      = 1'b1;
            tmc_wid_exp  = d.wid;
            tmc_mask_exp = exec_pkg::tmask_t'(mask_num);
        end else begin
            exp_result[pc] = res;
            exp_wid[pc]    = d.wid;
            expected_commits++;
        end
    endtask

    initial begin
        rst              = 1'b1;
        disp_valid       = 1'b0;
        disp_data        = '0;
        tmc_due          = 1'b0;
        mismatches       = 0;
        failures         = 0;
        commit_count     = 0;
        expected_commits = 0;
        for (int i = 0; i < exec_pkg::ISSUE_CNT; i++) begin
            br_due[i] = 1'b0;
        end
        void'($urandom(34516));
        repeat (4) @(negedge clk);
        rst = 1'b0;
        check_idle_outputs("after reset");

        fd = $fopen("testbench/exec_trace.txt", "r");
        if (fd == 0) begin
            failures++;
            $display("could not open testbench/exec_trace.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#") begin
                    if ($sscanf(line, "%d %d %d %h %h %h %h %h %d %h", idle, wid_num, op_num,
                                pc, rs1, rs2, imm, res, taken_num, mask_num) == 10) begin
                        issue_line();
                    end
                end
            end
            $fclose(fd);
        end

        wait_cycles = 0;
        while (commit_count < expected_commits && wait_cycles < 100) begin
            drive_cycle(1'b0, '0);
            wait_cycles++;
        end
        if (commit_count < expected_commits) begin
            failures++;
            $display("timed out waiting for commits, %0d of %0d arrived",
                     commit_count, expected_commits);
        end
        // a few quiet cycles catch any late duplicate commit
        repeat (4) drive_cycle(1'b0, '0);
        check_idle_outputs("after drain");
        check_value(commit_count, expected_commits, "total commit count");

        $display("errors: %0d mismatches, %0d other failures, %0d of %0d commits seen",
                 mismatches, failures, commit_count, expected_commits);
        if (mismatches == 0 && failures == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: files.f
hw/exec_pkg.sv
hw/issue_dispatcher.sv
hw/alu_slice.sv
hw/commit_merger.sv
hw/warp_ctl_unit.sv
hw/execute_scalar.sv
testbench/tb_execute_scalar.sv

// File: Bender.yml
package:
  name: execute_scalar

sources:
  - files:
      - hw/exec_pkg.sv
      - hw/issue_dispatcher.sv
      - hw/alu_slice.sv
      - hw/commit_merger.sv
      - hw/warp_ctl_unit.sv
      - hw/execute_scalar.sv
  - target: simulation
    files:
      - testbench/tb_execute_scalar.sv

// File: testbench/exec_trace.txt
# idle wid op pc rs1 rs2 imm result taken tmask  (idle, wid, op, taken decimal, rest hex)
# op: 0 ADD 1 SUB 2 AND 3 OR 4 XOR 5 SLT 6 SLTU 7 MUL 8 BEQ 9 BNE 10 JAL 11 TMC 12 EBREAK 13 ECALL
2 1 0 00000100 00000005 00000007 00000000 0000000c 0 0
1 2 1 00000104 00000010 00000003 00000000 0000000d 0 0
1 3 2 00000108 f0f0f0f0 0ff00ff0 00000000 00f000f0 0 0
0 4 3 0000010c 12340000 00005678 00000000 12345678 0 0
0 5 4 00000110 ffff0000 0f0f0f0f 00000000 f0f00f0f 0 0
1 6 5 00000114 fffffffe 00000001 00000000 00000001 0 0
0 7 6 00000118 fffffffe 00000001 00000000 00000000 0 0
1 0 5 0000011c 00000003 80000000 00000000 00000000 0 0
2 1 7 00000120 00001234 00000010 00000000 00012340 0 0
0 2 0 00000124 7fffffff 00000001 00000000 80000000 0 0
0 3 1 00000128 00000000 00000001 00000000 ffffffff 0 0
0 0 4 0000012c aaaaaaaa 55555555 00000000 ffffffff 0 0
0 1 0 00000130 00000002 00000003 00000000 00000005 0 0
2 6 7 00000134 ffffffff 00000003 00000000 fffffffd 0 0
0 6 6 00000138 00000001 00000002 00000000 00000001 0 0
0 2 3 0000013c 0000ff00 000000ff 00000000 0000ffff 0 0
0 7 7 00000140 00010000 00010000 00000000 00000000 0 0
2 1 8 00000200 00000005 00000005 00000040 00000204 1 0
1 2 8 00000208 00000005 00000006 00000010 0000020c 0 0
0 3 9 00000210 00000001 00000002 fffffff0 00000214 1 0
0 4 9 00000218 00000009 00000009 00000020 0000021c 0 0
1 5 10 00000220 00000000 00000000 00000100 00000224 1 0
2 3 11 00000300 0000000b 00000000 00000000 00000000 0 b
1 6 11 00000304 00000000 00000000 00000000 00000000 0 0
1 5 11 00000308 000000f7 00000000 00000000 00000000 0 7
2 0 12 00000400 00000000 00000000 00000000 00000404 0 0
1 4 12 00000408 00000000 00000000 00000000 0000040c 0 0
1 0 13 00000410 00000000 00000000 00000000 00000414 0 0
0 2 13 00000418 00000000 00000000 00000000 0000041c 0 0
